// File: project.f
source/bpu_pkg.sv
source/bpu_update_if.sv
source/inst_predecode.sv
source/pred_table.sv
source/direction_predictor.sv
source/branch_target_buffer.sv
source/return_stack.sv
source/target_select.sv
source/bpu_top.sv
verification/bpu_asserts.sv
verification/bpu_tb.sv

// File: source/bpu_pkg.sv
package bpu_pkg;

    // address and instruction width
    localparam int xlen_c = 32;

    typedef logic [xlen_c-1:0] addr_t;
    typedef logic [xlen_c-1:0] inst_t;

    // global history
    localparam int hist_len_c = 16;
    typedef logic [hist_len_c-1:0] hist_t;

    // bimodal table, indexed by pc[9:1]
    localparam int bim_entries_c = 512;
    typedef logic [$clog2(bim_entries_c)-1:0] bim_idx_t;

    // btb, indexed by pc[9:2], tagged by pc[31:10]
    localparam int btb_entries_c = 256;
    typedef logic [$clog2(btb_entries_c)-1:0] btb_idx_t;
    localparam int btb_tag_w_c = 22;
    typedef logic [btb_tag_w_c-1:0] btb_tag_t;

    // return stack, pointer one bit wider so a full count fits
    localparam int ras_depth_c = 32;
    typedef logic [$clog2(ras_depth_c):0] ras_ptr_t;

    // two-bit saturating counter
    typedef logic [1:0] ctr_t;
    localparam ctr_t ctr_weak_nt_c = 2'b01;

    typedef struct packed {
        logic     valid;
        btb_tag_t tag;
        addr_t    target;
    } btb_entry_t;

    localparam btb_entry_t btb_entry_empty_c = '{valid: 1'b0, tag: '0, target: '0};

    // rv32 opcodes of interest
    localparam logic [6:0] opc_branch_c = 7'b1100011;
    localparam logic [6:0] opc_jal_c    = 7'b1101111;
    localparam logic [6:0] opc_jalr_c   = 7'b1100111;

    // register numbers used by the return rule
    localparam logic [4:0] reg_zero_c = 5'd0;
    localparam logic [4:0] reg_ra_c   = 5'd1;  // x1
    localparam logic [4:0] reg_t0_c   = 5'd5;  // x5, alternate link

    typedef enum logic [2:0] {
        cls_none,
        cls_branch,
        cls_jal,
        cls_jalr,
        cls_ret
    } inst_class_t;

endpackage

// File: source/bpu_top.sv
`timescale 1ns/10ps

module bpu_top import bpu_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  addr_t if_pc_i,
    input  inst_t if_inst_i,
    input  logic  ex_branch_valid_i,
    input  logic  ex_branch_taken_i,
    input  addr_t ex_pc_i,
    input  addr_t ex_target_i,
    input  inst_t ex_inst_i,
    input  logic  id_ras_push_valid_i,
    input  addr_t id_ras_push_data_i,
    input  logic  ex_stall_valid_i,
    output logic  branch_or_not_o,
    output addr_t pdt_pc_o,
    output logic  pdt_res_o,
    output hist_t history_o
);

    inst_class_t if_class;
    addr_t       if_b_off;
    addr_t       if_j_off;
    logic        dir_taken;
    logic        btb_hit;
    addr_t       btb_target;
    logic        ras_valid;
    addr_t       ras_top;

    bpu_update_if upd_bus ();

    assign upd_bus.valid  = ex_branch_valid_i;
    assign upd_bus.taken  = ex_branch_taken_i;
    assign upd_bus.pc     = ex_pc_i;
    assign upd_bus.target = ex_target_i;

    // fetch side
    inst_predecode u_if_dec (
        .inst_i     (if_inst_i),
        .class_o    (if_class),
        .b_offset_o (if_b_off),
        .j_offset_o (if_j_off)
    );

    // execute side, only the class feeds the stack pop
    inst_predecode u_ex_dec (
        .inst_i     (ex_inst_i),
        .class_o    (upd_bus.cls),
        .b_offset_o (),
        .j_offset_o ()
    );

    direction_predictor u_dir (
        .clk        (clk),
        .rst        (rst),
        .fetch_pc_i (if_pc_i),
        .taken_o    (dir_taken),
        .upd        (upd_bus.sink),
        .history_o  (history_o)
    );

    branch_target_buffer u_btb (
        .clk        (clk),
        .rst        (rst),
        .fetch_pc_i (if_pc_i),
        .hit_o      (btb_hit),
        .target_o   (btb_target),
        .upd        (upd_bus.sink)
    );

    return_stack u_ras (
        .clk          (clk),
        .rst          (rst),
        .push_valid_i (id_ras_push_valid_i),
        .push_data_i  (id_ras_push_data_i),
        .stall_i      (ex_stall_valid_i),
        .upd          (upd_bus.sink),
        .top_valid_o  (ras_valid),
        .top_o        (ras_top)
    );

    target_select u_sel (
        .fetch_pc_i      (if_pc_i),
        .class_i         (if_class),
        .b_offset_i      (if_b_off),
        .j_offset_i      (if_j_off),
        .taken_i         (dir_taken),
        .btb_hit_i       (btb_hit),
        .btb_target_i    (btb_target),
        .ras_valid_i     (ras_valid),
        .ras_top_i       (ras_top),
        .branch_or_not_o (branch_or_not_o),
        .pdt_pc_o        (pdt_pc_o),
        .pdt_res_o       (pdt_res_o)
    );

endmodule

// File: source/bpu_update_if.sv
`timescale 1ns/10ps

// resolved-branch feedback from execute, single-cycle strobe, no handshake
interface bpu_update_if import bpu_pkg::*; ();

    logic        valid;   // one resolved control transfer this cycle
    logic        taken;
    addr_t       pc;
    addr_t       target;
    inst_class_t cls;     // class of the executed instruction

    modport source (
        output valid,
        output taken,
        output pc,
        output target,
        output cls
    );

    modport sink (
        input valid,
        input taken,
        input pc,
        input target,
        input cls
    );

endinterface

// File: source/branch_target_buffer.sv
`timescale 1ns/10ps

module branch_target_buffer import bpu_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  addr_t      fetch_pc_i,
    output logic       hit_o,
    output addr_t      target_o,
    bpu_update_if.sink upd
);

    btb_idx_t   fetch_idx;
    btb_tag_t   fetch_tag;
    btb_idx_t   upd_idx;
    btb_entry_t rd_entry;
    btb_entry_t wr_entry;
    logic       wr_en;

    assign fetch_idx = fetch_pc_i[9:2];
    assign fetch_tag = fetch_pc_i[xlen_c-1:xlen_c-btb_tag_w_c];
    assign upd_idx   = upd.pc[9:2];

    assign hit_o    = rd_entry.valid && (rd_entry.tag == fetch_tag);
    assign target_o = rd_entry.target;

    // only taken transfers allocate, not-taken leaves the slot alone
    assign wr_en           = upd.valid && upd.taken;
    assign wr_entry.valid  = 1'b1;
    assign wr_entry.tag    = upd.pc[xlen_c-1:xlen_c-btb_tag_w_c];
    assign wr_entry.target = upd.target;

    pred_table #(
        .entry_t     (btb_entry_t),
        .DEPTH       (btb_entries_c),
        .RESET_ENTRY (btb_entry_empty_c)
    ) u_btb_tab (
        .clk        (clk),
        .rst        (rst),
        .rd_idx_i   (fetch_idx),
        .rd_entry_o (rd_entry),
        .wr_en_i    (wr_en),
        .wr_idx_i   (upd_idx),
        .wr_entry_i (wr_entry)
    );

endmodule

// File: source/direction_predictor.sv
`timescale 1ns/10ps

module direction_predictor import bpu_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  addr_t      fetch_pc_i,
    output logic       taken_o,
    bpu_update_if.sink upd,
    output hist_t      history_o
);

    bim_idx_t fetch_idx;
    bim_idx_t upd_idx;
    ctr_t     fetch_ctr;
    ctr_t     upd_ctr;
    ctr_t     next_ctr;
    hist_t    hist_q;

    assign fetch_idx = fetch_pc_i[9:1];
    assign upd_idx   = upd.pc[9:1];

    // msb of the counter gives the direction
    assign taken_o = fetch_ctr[1];

    // saturating step toward the resolved outcome
    always_comb begin
        next_ctr = upd_ctr;
        if (upd.taken) begin
            if (upd_ctr != 2'b11) next_ctr = upd_ctr + 2'd1;
        end else begin
            if (upd_ctr != 2'b00) next_ctr = upd_ctr - 2'd1;
        end
    end

    pred_table #(.entry_t(ctr_t), .DEPTH(bim_entries_c), .RESET_ENTRY(ctr_weak_nt_c)) u_fetch_tab (
        .clk        (clk),
        .rst        (rst),
        .rd_idx_i   (fetch_idx),
        .rd_entry_o (fetch_ctr),
        .wr_en_i    (upd.valid),
        .wr_idx_i   (upd_idx),
        .wr_entry_i (next_ctr)
    );

    // mirror copy, read at the execute pc so the update never steals the fetch lookup
    pred_table #(.entry_t(ctr_t), .DEPTH(bim_entries_c), .RESET_ENTRY(ctr_weak_nt_c)) u_upd_tab (
        .clk        (clk),
        .rst        (rst),
        .rd_idx_i   (upd_idx),
        .rd_entry_o (upd_ctr),
        .wr_en_i    (upd.valid),
        .wr_idx_i   (upd_idx),
        .wr_entry_i (next_ctr)
    );

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            hist_q <= '0;
        end else if (upd.valid) begin
            hist_q <= {hist_q[hist_len_c-2:0], upd.taken};  // newest outcome at bit 0
        end
    end

    assign history_o = hist_q;

endmodule

// File: source/inst_predecode.sv
`timescale 1ns/10ps

module inst_predecode import bpu_pkg::*; (
    input  inst_t       inst_i,
    output inst_class_t class_o,
    output addr_t       b_offset_o,
    output addr_t       j_offset_o
);

    logic [6:0]  opcode;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [11:0] i_imm;
    logic        is_ret;

    assign opcode = inst_i[6:0];
    assign rd     = inst_i[11:7];
    assign rs1    = inst_i[19:15];
    assign i_imm  = inst_i[31:20];

    // strict return: jalr x0, 0(x1 or x5)
    assign is_ret = (rd == reg_zero_c)
                 && ((rs1 == reg_ra_c) || (rs1 == reg_t0_c))
                 && (i_imm == 12'd0);

    always_comb begin
        case (opcode)
            opc_branch_c: class_o = cls_branch;
            opc_jal_c:    class_o = cls_jal;
            opc_jalr_c:   class_o = is_ret ? cls_ret : cls_jalr;
            default:      class_o = cls_none;
        endcase
    end

    // b-type immediate, bit 0 always zero
    assign b_offset_o = {{20{inst_i[31]}},
                         inst_i[7],
                         inst_i[30:25],
                         inst_i[11:8],
                         1'b0};

    // j-type immediate
    assign j_offset_o = {{12{inst_i[31]}},
                         inst_i[19:12],
                         inst_i[20],
                         inst_i[30:21],
                         1'b0};

endmodule

// File: source/pred_table.sv
`timescale 1ns/10ps

// direct-mapped table, combinational read, clocked write
module pred_table #(
    parameter type    entry_t     = logic [1:0],
    parameter int     DEPTH       = 512,
    parameter entry_t RESET_ENTRY = '0
) (
    input  logic                     clk,
    input  logic                     rst,

    input  logic [$clog2(DEPTH)-1:0] rd_idx_i,
    output entry_t                   rd_entry_o,

    input  logic                     wr_en_i,
    input  logic [$clog2(DEPTH)-1:0] wr_idx_i,
    input  entry_t                   wr_entry_i
);

    entry_t mem [DEPTH];

    assign rd_entry_o = mem[rd_idx_i];

    // whole table returns to its reset entry
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < DEPTH; i++) begin
                mem[i] <= RESET_ENTRY;
            end
        end else if (wr_en_i) begin
            mem[wr_idx_i] <= wr_entry_i;
        end
    end

endmodule

// File: source/return_stack.sv
`timescale 1ns/10ps

module return_stack import bpu_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       push_valid_i,
    input  addr_t      push_data_i,
    input  logic       stall_i,
    bpu_update_if.sink upd,
    output logic       top_valid_o,
    output addr_t      top_o
);

    localparam int ptr_lo_w = $clog2(ras_depth_c);

    addr_t    stack_mem [ras_depth_c];
    ras_ptr_t sp_q;        // number of live entries
    ras_ptr_t top_ptr;
    ras_ptr_t sp_pop;
    logic     push_req;
    logic     pop_en;
    logic     push_en;

    assign push_req = push_valid_i && !stall_i;

    // pop on an executed return
    assign pop_en = upd.valid && upd.taken && (upd.cls == cls_ret)
                 && (sp_q != '0) && !stall_i;

    assign sp_pop  = pop_en ? sp_q - 1'b1 : sp_q;
    assign push_en = push_req && (sp_pop < ras_ptr_t'(ras_depth_c));  // full stack drops it

    assign top_ptr = sp_q - 1'b1;

    // same-cycle push wins over the stored top
    always_comb begin
        top_valid_o = 1'b0;
        top_o       = '0;
        if (push_req) begin
            top_valid_o = 1'b1;
            top_o       = push_data_i;
        end else if (sp_q != '0) begin
            top_valid_o = 1'b1;
            top_o       = stack_mem[top_ptr[ptr_lo_w-1:0]];
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            sp_q <= '0;
        end else begin
            sp_q <= push_en ? sp_pop + 1'b1 : sp_pop;
        end
    end

    // push lands on the slot freed by a same-cycle pop
    always_ff @(posedge clk) begin
        if (push_en) begin
            stack_mem[sp_pop[ptr_lo_w-1:0]] <= push_data_i;
        end
    end

endmodule

// File: source/target_select.sv
`timescale 1ns/10ps

module target_select import bpu_pkg::*; (
    input  addr_t       fetch_pc_i,
    input  inst_class_t class_i,
    input  addr_t       b_offset_i,
    input  addr_t       j_offset_i,
    input  logic        taken_i,
    input  logic        btb_hit_i,
    input  addr_t       btb_target_i,
    input  logic        ras_valid_i,
    input  addr_t       ras_top_i,
    output logic        branch_or_not_o,
    output addr_t       pdt_pc_o,
    output logic        pdt_res_o
);

    addr_t pc_plus4;

    assign pc_plus4 = fetch_pc_i + addr_t'(4);

    always_comb begin
        branch_or_not_o = 1'b0;
        pdt_res_o       = 1'b0;
        pdt_pc_o        = pc_plus4;  // fall through by default
        case (class_i)
            cls_ret: begin
                branch_or_not_o = 1'b1;
                pdt_res_o       = ras_valid_i;  // empty stack means no guess
                if (ras_valid_i) pdt_pc_o = ras_top_i;
            end
            cls_jal: begin
                branch_or_not_o = 1'b1;
                pdt_res_o       = 1'b1;
                pdt_pc_o        = btb_hit_i ? btb_target_i : fetch_pc_i + j_offset_i;
            end
            cls_branch: begin
                branch_or_not_o = 1'b1;
                pdt_res_o       = taken_i;
                if (taken_i) begin
                    pdt_pc_o = btb_hit_i ? btb_target_i : fetch_pc_i + b_offset_i;
                end
            end
            cls_jalr: begin
                // indirect target only known through the btb
                branch_or_not_o = 1'b1;
                pdt_res_o       = taken_i;
                if (btb_hit_i) pdt_pc_o = btb_target_i;
            end
            default: ;
        endcase
    end

endmodule

// File: verification/bpu_asserts.sv
`timescale 1ns/10ps

module bpu_asserts import bpu_pkg::*; (
    input logic        clk,
    input logic        rst,
    input inst_class_t fetch_class_i,
    input logic        branch_or_not_i,
    input logic        pdt_res_i,
    input ras_ptr_t    ras_count_i
);

    int assert_errs = 0;  // read by the testbench at the end

    // plain instructions never flag a transfer
    a_none_not_branch: assert property (@(posedge clk) disable iff (rst)
        (fetch_class_i == cls_none) |-> !branch_or_not_i)
        else begin
            $error("control transfer flagged for a non-control instruction");
            assert_errs++;
        end

    a_taken_is_branch: assert property (@(posedge clk) disable iff (rst)
        pdt_res_i |-> branch_or_not_i)
        else begin
            $error("taken prediction without a control transfer");
            assert_errs++;
        end

    a_ras_bound: assert property (@(posedge clk) disable iff (rst)
        ras_count_i <= ras_ptr_t'(ras_depth_c))
        else begin
            $error("return stack count beyond its depth");
            assert_errs++;
        end

endmodule

bind bpu_top bpu_asserts u_asserts (
    .clk             (clk),
    .rst             (rst),
    .fetch_class_i   (if_class),
    .branch_or_not_i (branch_or_not_o),
    .pdt_res_i       (pdt_res_o),
    .ras_count_i     (u_ras.sp_q)
);

// File: verification/bpu_tb.sv
`timescale 1ns/10ps

module bpu_tb import bpu_pkg::*; ();

    localparam int    timeout_cycles_c = 600;
    localparam int    seed_c           = 21776;
    localparam inst_t alu_inst_c       = 32'h0010_8093;  // addi x1, x1, 1
    localparam inst_t ret_inst_c       = 32'h0000_8067;  // jalr x0, 0(x1)

    logic  clk;
    logic  rst;
    addr_t if_pc;
    inst_t if_inst;
    logic  ex_valid;
    logic  ex_taken;
    addr_t ex_pc;
    addr_t ex_target;
    inst_t ex_inst;
    logic  push_valid;
    addr_t push_data;
    logic  stall;
    logic  branch_or_not;
    addr_t pdt_pc;
    logic  pdt_res;
    hist_t history;

    ctr_t  ctr_model [bim_entries_c];  // expected bimodal counters
    hist_t hist_model;
    int    bit_errs  = 0;
    int    addr_errs = 0;
    int    hist_errs = 0;
    int    cycle_cnt = 0;

    bpu_top DUT (
        .clk                 (clk),
        .rst                 (rst),
        .if_pc_i             (if_pc),
        .if_inst_i           (if_inst),
        .ex_branch_valid_i   (ex_valid),
        .ex_branch_taken_i   (ex_taken),
        .ex_pc_i             (ex_pc),
        .ex_target_i         (ex_target),
        .ex_inst_i           (ex_inst),
        .id_ras_push_valid_i (push_valid),
        .id_ras_push_data_i  (push_data),
        .ex_stall_valid_i    (stall),
        .branch_or_not_o     (branch_or_not),
        .pdt_pc_o            (pdt_pc),
        .pdt_res_o           (pdt_res),
        .history_o           (history)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

    initial begin
        wait (cycle_cnt >= timeout_cycles_c);
        $display("timeout: tests did not finish within %0d cycles", timeout_cycles_c);
        $display("Simulation FAILED");
        $finish;
    end

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("Mismatch %s: got 0x%0h expected 0x%0h", name, got, exp);
            bit_errs++;
        end
    endtask

    task automatic check_addr(input string name, input addr_t got, input addr_t exp);
        if (got !== exp) begin
            $display("Mismatch %s: got 0x%0h expected 0x%0h", name, got, exp);
            addr_errs++;
        end
    endtask

    task automatic check_hist(input string name, input hist_t got, input hist_t exp);
        if (got !== exp) begin
            $display("Mismatch %s: got 0x%0h expected 0x%0h", name, got, exp);
            hist_errs++;
        end
    endtask

    task automatic check_pred(input logic exp_bon, input logic exp_res, input addr_t exp_pc);
        check_bit("branch_or_not_o", branch_or_not, exp_bon);
        check_bit("pdt_res_o", pdt_res, exp_res);
        check_addr("pdt_pc_o", pdt_pc, exp_pc);
    endtask

    // beq x1, x2 with a 13-bit byte offset
    function automatic inst_t enc_branch(input logic [12:0] imm);
        return {imm[12], imm[10:5], 5'd2, 5'd1, 3'b000, imm[4:1], imm[11], opc_branch_c};
    endfunction

    // jal x1 with a 21-bit byte offset
    function automatic inst_t enc_jal(input logic [20:0] imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], 5'd1, opc_jal_c};
    endfunction

    // random tag bits, slot picks bits 9:2 so tests never share an index
    function automatic addr_t make_pc(input logic [7:0] slot);
        addr_t r;
        r = $urandom();
        return {r[31:10], slot, 2'b00};
    endfunction

    function automatic void model_update(input addr_t pc, input logic taken);
        bim_idx_t idx;
        idx = pc[9:1];
        if (taken && ctr_model[idx] != 2'b11) begin
            ctr_model[idx] = ctr_model[idx] + 2'd1;
        end else if (!taken && ctr_model[idx] != 2'b00) begin
            ctr_model[idx] = ctr_model[idx] - 2'd1;
        end
        hist_model = {hist_model[hist_len_c-2:0], taken};
    endfunction

    task automatic fetch(input addr_t pc, input inst_t inst);
        @(posedge clk);
        if_pc   <= pc;
        if_inst <= inst;
        @(negedge clk);  // prediction settled
    endtask

    task automatic resolve(input addr_t pc, input inst_t inst, input logic taken,
                           input addr_t tgt);
        @(posedge clk);
        ex_valid  <= 1'b1;
        ex_taken  <= taken;
        ex_pc     <= pc;
        ex_inst   <= inst;
        ex_target <= tgt;
        @(posedge clk);
        ex_valid <= 1'b0;
        model_update(pc, taken);
    endtask

    task automatic push(input addr_t data);
        @(posedge clk);
        push_valid <= 1'b1;
        push_data  <= data;
        @(posedge clk);
        push_valid <= 1'b0;
    endtask

    task automatic test_non_control();
        addr_t pc;
        pc = make_pc(8'h01);
        fetch(pc, alu_inst_c);
        check_pred(1'b0, 1'b0, pc + 4);
        check_hist("history_o", history, hist_model);
    endtask

    task automatic test_branch_counter();
        addr_t pc;
        addr_t tgt;
        inst_t inst;
        logic  exp_taken;
        pc   = make_pc(8'h10);
        inst = enc_branch(-13'sd32);
        tgt  = pc - 32'd32;
        fetch(pc, inst);
        check_pred(1'b1, 1'b0, pc + 4);
        // three taken then two not taken, 01 -> 10 -> 11 -> 11 -> 10 -> 01
        for (int i = 0; i < 5; i++) begin
            resolve(pc, inst, i < 3, tgt);
            fetch(pc, inst);
            exp_taken = ctr_model[pc[9:1]][1];
            check_pred(1'b1, exp_taken, exp_taken ? tgt : pc + 4);
        end
    endtask

    task automatic test_jal_btb();
        addr_t pc;
        addr_t alias_pc;
        addr_t tgt;
        inst_t inst;
        pc       = make_pc(8'h20);
        alias_pc = pc ^ 32'h0000_0400;  // same index, other tag
        tgt      = make_pc(8'h80);
        inst     = enc_jal(21'h01234);
        fetch(pc, inst);
        check_pred(1'b1, 1'b1, pc + 32'h1234);
        resolve(pc, inst, 1'b1, tgt);
        fetch(pc, inst);
        check_pred(1'b1, 1'b1, tgt);
        fetch(alias_pc, inst);
        check_pred(1'b1, 1'b1, alias_pc + 32'h1234);
    endtask

    task automatic test_return_stack();
        addr_t pc;
        addr_t ret_pc;
        addr_t a;
        addr_t b;
        addr_t c;
        pc     = make_pc(8'h30);
        ret_pc = make_pc(8'h31);
        a      = make_pc(8'h40);
        b      = make_pc(8'h41);
        c      = make_pc(8'h42);
        fetch(pc, ret_inst_c);
        check_pred(1'b1, 1'b0, pc + 4);
        push(a);
        push(b);
        fetch(pc, ret_inst_c);
        check_pred(1'b1, 1'b1, b);
        resolve(ret_pc, ret_inst_c, 1'b1, b);
        fetch(pc, ret_inst_c);
        check_pred(1'b1, 1'b1, a);
        // push in the fetch cycle bypasses the stack
        @(posedge clk);
        push_valid <= 1'b1;
        push_data  <= c;
        @(negedge clk);
        check_pred(1'b1, 1'b1, c);
        @(posedge clk);
        push_valid <= 1'b0;
        // stall holds both push and pop back
        @(posedge clk);
        push_valid <= 1'b1;
        push_data  <= b;
        stall      <= 1'b1;
        ex_valid   <= 1'b1;
        ex_taken   <= 1'b1;
        ex_pc      <= ret_pc;
        ex_inst    <= ret_inst_c;
        @(negedge clk);
        check_pred(1'b1, 1'b1, c);
        @(posedge clk);
        push_valid <= 1'b0;
        stall      <= 1'b0;
        ex_valid   <= 1'b0;
        model_update(ret_pc, 1'b1);  // history still shifts under stall
        fetch(pc, ret_inst_c);
        check_pred(1'b1, 1'b1, c);
        resolve(ret_pc, ret_inst_c, 1'b1, c);
        fetch(pc, ret_inst_c);
        check_pred(1'b1, 1'b1, a);
        resolve(ret_pc, ret_inst_c, 1'b1, a);
        fetch(pc, ret_inst_c);
        check_pred(1'b1, 1'b0, pc + 4);
    endtask

    task automatic test_full_stack();
        addr_t pc;
        addr_t ret_pc;
        addr_t base;
        pc     = make_pc(8'h50);
        ret_pc = make_pc(8'h51);
        base   = make_pc(8'h60);
        // one push more than the depth, the last is dropped
        for (int i = 0; i <= ras_depth_c; i++) begin
            push(base + addr_t'(4 * i));
        end
        for (int i = ras_depth_c - 1; i >= 0; i--) begin
            fetch(pc, ret_inst_c);
            check_pred(1'b1, 1'b1, base + addr_t'(4 * i));
            resolve(ret_pc, ret_inst_c, 1'b1, base);
        end
        fetch(pc, ret_inst_c);
        check_pred(1'b1, 1'b0, pc + 4);
    endtask

    task automatic test_history();
        addr_t pc;
        logic  taken;
        pc = make_pc(8'h70);
        for (int i = 0; i < 20; i++) begin
            taken = $urandom_range(1, 0);
            resolve(pc, enc_branch(13'd8), taken, pc + 32'd8);
            @(negedge clk);
            check_hist("history_o", history, hist_model);
        end
    endtask

    initial begin
        void'($urandom(seed_c));
        rst        = 1'b1;
        if_pc      = '0;
        if_inst    = '0;
        ex_valid   = 1'b0;
        ex_taken   = 1'b0;
        ex_pc      = '0;
        ex_target  = '0;
        ex_inst    = '0;
        push_valid = 1'b0;
        push_data  = '0;
        stall      = 1'b0;
        hist_model = '0;
        for (int i = 0; i < bim_entries_c; i++) begin
            ctr_model[i] = ctr_weak_nt_c;
        end
        repeat (8) @(posedge clk);
        rst <= 1'b0;

        test_non_control();
        test_branch_counter();
        test_jal_btb();
        test_return_stack();
        test_full_stack();
        test_history();

        @(posedge clk);
        $display("errors: bit %0d, addr %0d, hist %0d, assert %0d",
                 bit_errs, addr_errs, hist_errs, DUT.u_asserts.assert_errs);
        if (bit_errs + addr_errs + hist_errs + DUT.u_asserts.assert_errs == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule
